// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= hazDetTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
PASSMSG   := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: bench/hazDetTb.sv
`timescale 1ns/1ps
`default_nettype none

module hazDetTb;

    logic        clk = 1'b0;
    logic        rstN;
    logic [15:0] instr;
    logic [2:0]  rd;
    logic        regWrite;
    logic        memEnable;
    logic [15:0] imm;
    logic [15:0] rsData;
    logic        branchTaken;
    logic        cfgReq;
    logic [1:0]  cfgWrData;
    logic        stall;
    logic [3:0]  forwards;
    logic        cfgAck;
    logic [1:0]  cfgRdData;

    // Reference shadows with index 0 as ID and 3 as WB
    logic [2:0]  mRd [4];
    logic        mWr [4];
    logic        mLd [4];
    logic [15:0] mAddr [4];
    logic        mMen [4];
    logic        fwdOn;
    logic        memOn;
    int          errors = 0;
    int          checks = 0;
    int          seed = 32'hd5535794;
    string       testName;

    hazDet dut (.*);

    always #10 clk = ~clk;

    initial begin
        #2ms;
        $display("global timeout, simulation did not finish");
        $display("tests failed");
        $finish;
    end

    function automatic logic [15:0] mkInstr(logic [4:0] op, logic [2:0] rs, logic [2:0] rt);
        return {op, rs, rt, 5'b00000};
    endfunction

    task automatic clearModel();
        for (int s = 0; s < 4; s++) begin
            mRd[s] = '0;
            mWr[s] = 1'b0;
            mLd[s] = 1'b0;
            mAddr[s] = '0;
            mMen[s] = 1'b0;
        end
    endtask

    // Predict from the hazard rules, compare, then advance the shadows
    task automatic checkCycle(output logic expStall);
        logic [2:0]  rsI;
        logic [2:0]  rtI;
        logic [15:0] addr;
        logic        jal;
        logic        hitRs [4];
        logic        hitRt [4];
        logic        anyReg;
        logic        anyMem;
        logic [3:0]  expFwd;
        @(negedge clk);
        rsI = instr[10:8];
        rtI = instr[7:5];
        addr = rsData + imm;
        jal = (instr[15:12] == 4'b0011);
        anyReg = 1'b0;
        anyMem = 1'b0;
        for (int s = 0; s < 4; s++) begin
            hitRs[s] = mWr[s] && (mRd[s] == rsI) && !(s == 0 && branchTaken);
            hitRt[s] = mWr[s] && (mRd[s] == rtI) && !(s == 0 && branchTaken);
            anyReg = anyReg | hitRs[s] | hitRt[s];
            if (mMen[s] && mAddr[s] == addr && !(s == 0 && branchTaken))
                anyMem = 1'b1;
        end
        if (fwdOn) begin
            expFwd = {hitRs[0], hitRs[1] & ~hitRs[0], hitRt[0], hitRt[1] & ~hitRt[0]};
            expStall = (hitRs[0] | hitRt[0]) & mLd[0];
        end else begin
            expFwd = 4'b0000;
            expStall = anyReg;
        end
        expStall = expStall | (memEnable & memOn & anyMem);
        checks++;
        if (stall !== expStall) begin
            $display("mismatch %s stall expected %0b actual %0b", testName, expStall, stall);
            errors++;
        end
        if (forwards !== expFwd) begin
            $display("mismatch %s forwards expected %4b actual %4b", testName, expFwd, forwards);
            errors++;
        end
        for (int s = 3; s > 1; s--) begin
            mRd[s] = mRd[s-1];
            mWr[s] = mWr[s-1];
            mLd[s] = mLd[s-1];
            mAddr[s] = mAddr[s-1];
            mMen[s] = mMen[s-1];
        end
        mRd[1] = mRd[0];
        mWr[1] = mWr[0] & ~branchTaken;
        mLd[1] = mLd[0] & ~branchTaken;
        mAddr[1] = branchTaken ? '0 : mAddr[0];
        mMen[1] = mMen[0] & ~branchTaken;
        if (branchTaken)
            mRd[1] = '0;
        mRd[0] = expStall ? 3'd0 : (jal ? 3'd7 : rd);
        mWr[0] = !expStall && (regWrite || jal);
        mLd[0] = !expStall && regWrite && memEnable;
        mAddr[0] = expStall ? 16'h0 : addr;
        mMen[0] = !expStall && memEnable;
    endtask

    // Offer one instruction and hold it until it issues
    task automatic issue(input logic [15:0] ins, input logic [2:0] rdv, input logic wr,
                         input logic men, input logic [15:0] rsd, input logic [15:0] immv,
                         input logic br, output int stalls);
        logic st;
        stalls = 0;
        @(posedge clk);
        instr <= ins;
        rd <= rdv;
        regWrite <= wr;
        memEnable <= men;
        rsData <= rsd;
        imm <= immv;
        branchTaken <= br;
        for (int t = 0; t < 20; t++) begin
            checkCycle(st);
            if (!st)
                break;
            stalls++;
            if (t == 19) begin
                $display("%s: instruction never issued", testName);
                errors++;
            end
            @(posedge clk);
        end
    endtask

    task automatic nop(input int n);
        int s;
        for (int i = 0; i < n; i++)
            issue(16'h0, 3'd0, 1'b0, 1'b0, 16'h0, 16'h0, 1'b0, s);
    endtask

    task automatic expectStalls(input int exp, input int got);
        if (exp != got) begin
            $display("mismatch %s stall cycles expected %0d actual %0d", testName, exp, got);
            errors++;
        end
    endtask

    task automatic writeCfg(input logic [1:0] word);
        int t;
        nop(4);
        @(posedge clk);
        cfgReq <= 1'b1;
        cfgWrData <= word;
        for (t = 0; t < 10 && !cfgAck; t++)
            @(negedge clk);
        if (!cfgAck) begin
            $display("%s: cfgAck did not rise", testName);
            errors++;
        end
        @(posedge clk);
        cfgReq <= 1'b0;
        for (t = 0; t < 10 && cfgAck; t++)
            @(negedge clk);
        if (cfgAck) begin
            $display("%s: cfgAck did not fall", testName);
            errors++;
        end
        if (cfgRdData !== word) begin
            $display("mismatch %s cfgRdData expected %2b actual %2b", testName, word, cfgRdData);
            errors++;
        end
        fwdOn = word[1];
        memOn = word[0];
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        clearModel();
        fwdOn = 1'b1;
        memOn = 1'b1;
    endtask

    task automatic testConfig();
        testName = "config";
        for (int w = 0; w < 4; w++)
            writeCfg(w[1:0]);
        writeCfg(2'b00);
        applyReset();
        @(negedge clk);
        if (cfgRdData !== 2'b11) begin
            $display("mismatch %s reset word expected 11 actual %2b", testName, cfgRdData);
            errors++;
        end
    endtask

    task automatic testNoFwd();
        int s;
        testName = "noForward";
        writeCfg(2'b01);
        issue(mkInstr(5'd1, 3'd1, 3'd2), 3'd3, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd3, 3'd2), 3'd4, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        expectStalls(4, s);
        issue(mkInstr(5'd1, 3'd1, 3'd2), 3'd5, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        expectStalls(0, s);
        issue(mkInstr(5'd1, 3'd6, 3'd1), 3'd2, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        expectStalls(0, s);
    endtask

    task automatic testFwd();
        int s;
        testName = "forward";
        writeCfg(2'b11);
        issue(mkInstr(5'd1, 3'd1, 3'd1), 3'd2, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd1, 3'd1), 3'd3, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd3, 3'd2), 3'd3, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd3, 3'd3), 3'd5, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        expectStalls(0, s);
        issue(mkInstr(5'd2, 3'd1, 3'd1), 3'd4, 1'b1, 1'b1, 16'h10, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd1, 3'd4), 3'd6, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        expectStalls(1, s);
    endtask

    task automatic testJal();
        int s;
        testName = "jumpLink";
        writeCfg(2'b01);
        issue(mkInstr(5'b00111, 3'd0, 3'd0), 3'd1, 1'b0, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd7, 3'd2), 3'd3, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        expectStalls(4, s);
    endtask

    task automatic testMem();
        int s;
        testName = "memory";
        writeCfg(2'b11);
        issue(16'h0, 3'd0, 1'b0, 1'b1, 16'h100, 16'h20, 1'b0, s);
        issue(16'h0, 3'd0, 1'b0, 1'b1, 16'h110, 16'h10, 1'b0, s);
        expectStalls(4, s);
        writeCfg(2'b10);
        issue(16'h0, 3'd0, 1'b0, 1'b1, 16'h100, 16'h20, 1'b0, s);
        issue(16'h0, 3'd0, 1'b0, 1'b1, 16'h110, 16'h10, 1'b0, s);
        expectStalls(0, s);
        testName = "memoryRandom";
        for (int i = 0; i < 60; i++) begin
            if (i == 30)
                writeCfg(2'b01);
            issue(16'($random(seed)), 3'($random(seed)), 1'($random(seed)),
                  1'($random(seed)), 16'($random(seed) & 16'h3),
                  16'($random(seed) & 16'h3), 1'b0, s);
        end
    endtask

    task automatic testSquash();
        int s;
        testName = "squash";
        writeCfg(2'b01);
        issue(mkInstr(5'd1, 3'd1, 3'd1), 3'd5, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd5, 3'd2), 3'd6, 1'b1, 1'b0, 16'h0, 16'h0, 1'b1, s);
        expectStalls(0, s);
        writeCfg(2'b11);
        issue(mkInstr(5'd1, 3'd1, 3'd1), 3'd5, 1'b1, 1'b0, 16'h0, 16'h0, 1'b0, s);
        issue(mkInstr(5'd1, 3'd5, 3'd5), 3'd6, 1'b1, 1'b0, 16'h0, 16'h0, 1'b1, s);
        if (forwards !== 4'b0000) begin
            $display("mismatch %s forwards expected 0000 actual %4b", testName, forwards);
            errors++;
        end
    endtask

    initial begin
        rstN = 1'b0;
        instr = '0;
        rd = '0;
        regWrite = 1'b0;
        memEnable = 1'b0;
        imm = '0;
        rsData = '0;
        branchTaken = 1'b0;
        cfgReq = 1'b0;
        cfgWrData = '0;
        clearModel();
        fwdOn = 1'b1;
        memOn = 1'b1;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        testConfig();
        testNoFwd();
        testFwd();
        testJal();
        testMem();
        testSquash();
        $display("errors %0d over %0d cycle checks", errors, checks);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/hazDet_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hazDetAssert (
    input wire logic       clk,
    input wire logic       rstN,
    input wire logic       cfgReq,
    input wire logic       cfgAck,
    input wire logic       forwardEn,
    input wire logic [3:0] forwards,
    input wire logic       stall
);

    // Ack only answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(cfgAck) |-> cfgReq)
        else $error("cfgAck rose without cfgReq");

    fwdOffQuiet: assert property (@(posedge clk) disable iff (!rstN)
        !forwardEn |-> forwards == 4'b0000)
        else $error("forwards set while forwarding is off");

    // Pipe is empty right after reset
    noStallAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> !stall)
        else $error("stall high in first cycle after reset");

endmodule

bind hazDet hazDetAssert hazChk (
    .clk       (clk),
    .rstN      (rstN),
    .cfgReq    (cfgReq),
    .cfgAck    (cfgAck),
    .forwardEn (forwardEn),
    .forwards  (forwards),
    .stall     (stall)
);

`default_nettype wire

// File: project.f
src/hazPkg.sv
src/stageView.sv
src/stageTrack.sv
src/regHazard.sv
src/memHazard.sv
src/hazCfg.sv
src/hazDet.sv
bench/hazDet_assert.sv
bench/hazDetTb.sv

// File: src/hazCfg.sv
`timescale 1ns/1ps
`default_nettype none

// Config word behind a four-phase req/ack port
module hazCfg (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    cfgReq,
    input  logic [hazPkg::cfgW-1:0] cfgWrData,
    output logic                    cfgAck,
    output logic [hazPkg::cfgW-1:0] cfgRdData,
    output logic                    forwardEn,
    output logic                    memCheckEn
);

    import hazPkg::*;

    typedef enum logic {
        cfgIdle,    // Waiting for a request
        cfgHold     // Acked, waiting for req to drop
    } cfgStateT;

    cfgStateT        state;
    logic [cfgW-1:0] cfgWord;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= cfgIdle;
            cfgWord <= cfgReset;
        end else begin
            case (state)
                cfgIdle: begin
                    if (cfgReq) begin
                        cfgWord <= cfgWrData;   // Host keeps data stable while req is up
                        state   <= cfgHold;
                    end
                end
                cfgHold: begin
                    if (!cfgReq) begin
                        state <= cfgIdle;
                    end
                end
                default: state <= cfgIdle;
            endcase
        end
    end

    assign cfgAck    = (state == cfgHold);
    assign cfgRdData = cfgWord;

    // Enables go to the checkers
    assign forwardEn  = cfgWord[cfgFwdBit];
    assign memCheckEn = cfgWord[cfgMemBit];

endmodule

`default_nettype wire

// File: src/hazDet.sv
`timescale 1ns/1ps
`default_nettype none

// Hazard unit of the five-stage pipe
module hazDet (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [hazPkg::instrW-1:0]  instr,
    input  logic [hazPkg::regIdxW-1:0] rd,
    input  logic                       regWrite,
    input  logic                       memEnable,
    input  logic [hazPkg::instrW-1:0]  imm,
    input  logic [hazPkg::instrW-1:0]  rsData,
    input  logic                       branchTaken,
    input  logic                       cfgReq,
    input  logic [hazPkg::cfgW-1:0]    cfgWrData,
    output logic                       stall,
    output logic [3:0]                 forwards,
    output logic                       cfgAck,
    output logic [hazPkg::cfgW-1:0]    cfgRdData
);

    import hazPkg::*;

    logic   forwardEn;
    logic   memCheckEn;
    logic   regStall;
    logic   memStall;
    regRecT regNew;
    memRecT memNew;

    stageView #(.recT(regRecT)) regView ();
    stageView #(.recT(memRecT)) memView ();

    hazCfg cfgBlk (
        .clk        (clk),
        .rstN       (rstN),
        .cfgReq     (cfgReq),
        .cfgWrData  (cfgWrData),
        .cfgAck     (cfgAck),
        .cfgRdData  (cfgRdData),
        .forwardEn  (forwardEn),
        .memCheckEn (memCheckEn)
    );

    // Destination tracker
    stageTrack #(.recT(regRecT), .emptyRec(regRecEmpty)) regTrack (
        .clk    (clk),
        .rstN   (rstN),
        .newRec (regNew),
        .bubble (stall),
        .squash (branchTaken),
        .view   (regView)
    );

    // Memory access tracker
    stageTrack #(.recT(memRecT), .emptyRec(memRecEmpty)) memTrack (
        .clk    (clk),
        .rstN   (rstN),
        .newRec (memNew),
        .bubble (stall),
        .squash (branchTaken),
        .view   (memView)
    );

    regHazard regChk (
        .instr     (instr),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .forwardEn (forwardEn),
        .view      (regView),
        .newRec    (regNew),
        .regStall  (regStall),
        .forwards  (forwards)
    );

    memHazard memChk (
        .rsData     (rsData),
        .imm        (imm),
        .memEnable  (memEnable),
        .memCheckEn (memCheckEn),
        .view       (memView),
        .newRec     (memNew),
        .memStall   (memStall)
    );

    assign stall = regStall | memStall;     // Host holds the instruction while high

endmodule

`default_nettype wire

// File: src/hazPkg.sv
`default_nettype none

package hazPkg;

    // Datapath widths
    localparam int instrW  = 16;            // Instruction, immediate, register data, address
    localparam int regIdxW = 3;

    // Instruction field positions
    localparam int opMsb = 15;
    localparam int opLsb = 11;
    localparam int rsMsb = 10;
    localparam int rsLsb = 8;
    localparam int rtMsb = 7;
    localparam int rtLsb = 5;

    // Jump-and-link class, low opcode bit is a don't care
    localparam logic [4:0] opJal = 5'b0011?;
    localparam logic [regIdxW-1:0] linkReg = 3'd7;   // Return address register

    // Register destination carried down the pipe
    typedef struct packed {
        logic [regIdxW-1:0] rd;
        logic               regWrite;
        logic               isLoad;     // Result only ready after MEM
    } regRecT;

    // Memory access carried down the pipe
    typedef struct packed {
        logic [instrW-1:0] addr;
        logic              memEnable;
    } memRecT;

    // Bubble values
    localparam regRecT regRecEmpty = '0;
    localparam memRecT memRecEmpty = '0;

    // Config word layout
    localparam int cfgW       = 2;
    localparam int cfgFwdBit  = 1;          // forwardEn
    localparam int cfgMemBit  = 0;          // memCheckEn
    localparam logic [cfgW-1:0] cfgReset = 2'b11;

endpackage

`default_nettype wire

// File: src/memHazard.sv
`timescale 1ns/1ps
`default_nettype none

// Holds back a memory access that hits an address still in flight
module memHazard (
    input  logic [hazPkg::instrW-1:0] rsData,
    input  logic [hazPkg::instrW-1:0] imm,
    input  logic                      memEnable,
    input  logic                      memCheckEn,
    stageView.check                   view,
    output hazPkg::memRecT            newRec,
    output logic                      memStall
);

    import hazPkg::*;

    logic [instrW-1:0] addr;
    logic              idHit;
    logic              exHit;
    logic              memHit;
    logic              wbHit;

    function automatic logic sameAccess(memRecT rec, logic [instrW-1:0] a);
        return rec.memEnable && (rec.addr == a);
    endfunction

    assign addr = rsData + imm;     // Base plus offset, wraps at 16 bits

    always_comb begin
        newRec.addr      = addr;
        newRec.memEnable = memEnable;
    end

    assign idHit  = sameAccess(view.idRec, addr);
    assign exHit  = sameAccess(view.exRec, addr);
    assign memHit = sameAccess(view.memRec, addr);
    assign wbHit  = sameAccess(view.wbRec, addr);

    assign memStall = memEnable & memCheckEn & (idHit | exHit | memHit | wbHit);

endmodule

`default_nettype wire

// File: src/regHazard.sv
`timescale 1ns/1ps
`default_nettype none

// Register RAW check against the in-flight destinations
module regHazard (
    input  logic [hazPkg::instrW-1:0]  instr,
    input  logic [hazPkg::regIdxW-1:0] rd,
    input  logic                       regWrite,
    input  logic                       memEnable,
    input  logic                       forwardEn,
    stageView.check                    view,
    output hazPkg::regRecT             newRec,
    output logic                       regStall,
    output logic [3:0]                 forwards
);

    import hazPkg::*;

    logic [regIdxW-1:0] rs;
    logic [regIdxW-1:0] rt;
    logic               isJal;
    logic               idRs;
    logic               idRt;
    logic               exRs;
    logic               exRt;
    logic               lateRs;     // MEM or WB writes rs
    logic               lateRt;
    logic               loadUse;

    function automatic logic writesReg(regRecT rec, logic [regIdxW-1:0] idx);
        return rec.regWrite && (rec.rd == idx);
    endfunction

    assign rs    = instr[rsMsb:rsLsb];
    assign rt    = instr[rtMsb:rtLsb];
    assign isJal = instr[opMsb:opLsb] ==? opJal;

    // Record of the instruction on offer
    always_comb begin
        newRec.rd       = isJal ? linkReg : rd;     // Link always lands in r7
        newRec.regWrite = regWrite | isJal;
        newRec.isLoad   = memEnable & regWrite;
    end

    assign idRs   = writesReg(view.idRec, rs);
    assign idRt   = writesReg(view.idRec, rt);
    assign exRs   = writesReg(view.exRec, rs);
    assign exRt   = writesReg(view.exRec, rt);
    assign lateRs = writesReg(view.memRec, rs) | writesReg(view.wbRec, rs);
    assign lateRt = writesReg(view.memRec, rt) | writesReg(view.wbRec, rt);

    // Load data is not there yet when the consumer reaches EX
    assign loadUse = (idRs | idRt) & view.idRec.isLoad;

    always_comb begin
        if (forwardEn) begin
            // Youngest producer wins
            forwards = {idRs, exRs & ~idRs, idRt, exRt & ~idRt};
            regStall = loadUse;
        end else begin
            forwards = 4'b0000;
            regStall = idRs | idRt | exRs | exRt | lateRs | lateRt;
        end
    end

endmodule

`default_nettype wire

// File: src/stageTrack.sv
`timescale 1ns/1ps
`default_nettype none

// Follows one record per instruction through ID, EX, MEM and WB
module stageTrack #(
    parameter type recT     = logic,
    parameter recT emptyRec = '0
) (
    input  logic       clk,
    input  logic       rstN,
    input  recT        newRec,
    input  logic       bubble,     // Issue held back this cycle
    input  logic       squash,     // Taken branch kills the ID instruction
    stageView.track    view
);

    recT idReg;
    recT exReg;
    recT memReg;
    recT wbReg;
    recT idLive;

    // A squashed instruction is gone for the checkers as well
    assign idLive = squash ? emptyRec : idReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idReg  <= emptyRec;
            exReg  <= emptyRec;
            memReg <= emptyRec;
            wbReg  <= emptyRec;
        end else begin
            idReg  <= bubble ? emptyRec : newRec;   // Stalled instruction stays with the host
            exReg  <= idLive;
            memReg <= exReg;
            wbReg  <= memReg;
        end
    end

    assign view.idRec  = idLive;
    assign view.exRec  = exReg;
    assign view.memRec = memReg;
    assign view.wbRec  = wbReg;

endmodule

`default_nettype wire

// File: src/stageView.sv
`timescale 1ns/1ps
`default_nettype none

// Live view of one tracker, one record per pipeline stage
interface stageView #(
    parameter type recT = logic
) ();

    recT idRec;     // Already masked by squash
    recT exRec;
    recT memRec;
    recT wbRec;

    modport track (
        output idRec,
        output exRec,
        output memRec,
        output wbRec
    );

    modport check (
        input idRec,
        input exRec,
        input memRec,
        input wbRec
    );

endinterface

`default_nettype wire
